// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tri_hit_tb
FILELIST  ?= tri_hit_top.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/credit_fifo.sv ====
module credit_fifo import tri_pkg::*; #(
    parameter type payload_t = tri_in_t
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_valid,
    input  payload_t wr_data,
    input  logic     pop,
    output payload_t rd_data,
    output logic     empty,
    output logic     credit
);

    // storage, no reset needed on the entries
    payload_t mem [fifo_depth];

    logic [fifo_ptr_w-1:0]   wr_ptr;
    logic [fifo_ptr_w-1:0]   rd_ptr;
    logic [fifo_count_w-1:0] count;
    logic                    do_pop;

    // wrap at fifo_depth, also correct for depths that are not a power of two
    function automatic logic [fifo_ptr_w-1:0] next_ptr(input logic [fifo_ptr_w-1:0] ptr);
        logic [fifo_ptr_w-1:0] nxt;
        if (ptr == fifo_ptr_w'(fifo_depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // occupancy is registered, so a write shows up one cycle later
    assign empty   = (count == '0);
    // a pop on an empty FIFO is ignored
    assign do_pop  = pop && !empty;
    // one credit back per freed entry, same cycle as the pop
    assign credit  = do_pop;
    // head entry always on the read port
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // writer never exceeds its credits, so no full check here
            case ({wr_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/cross_stage.sv ====
module cross_stage import tri_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  edge_t  in_data,
    input  logic   in_empty,
    input  logic   out_credit,
    output logic   in_pop,
    output logic   out_valid,
    output cross_t out_data
);

    credit_t credits;
    // bit 0 after products, bit 1 after differences
    logic [1:0] v_q;

    // edge and point vectors as arrays for the loops
    vec3_t e [3];
    vec3_t p [3];

    // first and second term of each cross component
    prod_t pa_q [3][3];
    prod_t pb_q [3][3];
    vec3_t normal_q;

    // shifted and truncated cross products
    vec3_t c_d [3];

    assign e[0] = in_data.e0;
    assign e[1] = in_data.e1;
    assign e[2] = in_data.e2;
    assign p[0] = in_data.p0;
    assign p[1] = in_data.p1;
    assign p[2] = in_data.p2;

    // both pipeline slots may hold an item not yet charged to the counter
    assign in_pop    = !in_empty && (credits > credit_t'(v_q[0]) + credit_t'(v_q[1]));
    assign out_valid = v_q[1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= credit_t'(fifo_depth);
            v_q     <= 2'b00;
        end else begin
            credits <= credits + credit_t'(out_credit) - credit_t'(out_valid);
            v_q     <= {v_q[0], in_pop};
        end
    end

    // register 1: eighteen partial products
    // component k of e x p is e[k+1]*p[k+2] - e[k+2]*p[k+1], indices mod 3
    always_ff @(posedge clock) begin
        if (in_pop) begin
            for (int i = 0; i < 3; i++) begin
                for (int k = 0; k < 3; k++) begin
                    pa_q[i][k] <= mul_wide(e[i][(k + 1) % 3], p[i][(k + 2) % 3]);
                    pb_q[i][k] <= mul_wide(e[i][(k + 2) % 3], p[i][(k + 1) % 3]);
                end
            end
            normal_q <= in_data.normal;
        end
    end

    // difference in 64 bits, back to q22.10, then cut to 32
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            for (int k = 0; k < 3; k++) begin
                c_d[i][k] = coord_t'((pa_q[i][k] - pb_q[i][k]) >>> q_bits);
            end
        end
    end

    // register 2: cross products out
    always_ff @(posedge clock) begin
        if (v_q[0]) begin
            out_data.c0     <= c_d[0];
            out_data.c1     <= c_d[1];
            out_data.c2     <= c_d[2];
            out_data.normal <= normal_q;
        end
    end

endmodule

// ==== source/edge_sub_stage.sv ====
module edge_sub_stage import tri_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  tri_in_t in_data,
    input  logic    in_empty,
    input  logic    out_credit,
    output logic    in_pop,
    output logic    out_valid,
    output edge_t   out_data
);

    // credits for the FIFO in front of the cross stage
    credit_t credits;
    // item currently in the output register
    credit_t in_flight;

    // out_valid marks an item whose credit is not yet taken from the counter
    assign in_flight = credit_t'(out_valid);

    // pop only with a free credit left after the in flight item
    assign in_pop = !in_empty && (credits > in_flight);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits   <= credit_t'(fifo_depth);
            out_valid <= 1'b0;
        end else begin
            // returned credit and send can fall in the same cycle
            credits   <= credits + credit_t'(out_credit) - credit_t'(out_valid);
            // one cycle from pop to valid
            out_valid <= in_pop;
        end
    end

    // payload, loaded on pop only
    always_ff @(posedge clock) begin
        if (in_pop) begin
            // triangle edges
            out_data.e0     <= vec_sub(in_data.v1, in_data.v0);
            out_data.e1     <= vec_sub(in_data.v2, in_data.v1);
            out_data.e2     <= vec_sub(in_data.v0, in_data.v2);
            // vertex to hit point
            out_data.p0     <= vec_sub(in_data.p_hit, in_data.v0);
            out_data.p1     <= vec_sub(in_data.p_hit, in_data.v1);
            out_data.p2     <= vec_sub(in_data.p_hit, in_data.v2);
            // normal passes straight on
            out_data.normal <= in_data.normal;
        end
    end

endmodule

// ==== source/sign_test_stage.sv ====
module sign_test_stage import tri_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  cross_t in_data,
    input  logic   in_empty,
    input  logic   out_credit,
    output logic   in_pop,
    output logic   hit_valid,
    output logic   hit
);

    // credits of the external consumer
    credit_t credits;
    logic [1:0] v_q;

    vec3_t c [3];
    // normal times each cross component
    prod_t m_q [3][3];
    // dot products, kept at 64 bits
    prod_t d [3];
    logic  hit_d;

    assign c[0] = in_data.c0;
    assign c[1] = in_data.c1;
    assign c[2] = in_data.c2;

    // same in flight accounting as the cross stage
    assign in_pop    = !in_empty && (credits > credit_t'(v_q[0]) + credit_t'(v_q[1]));
    assign hit_valid = v_q[1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= credit_t'(out_credits);
            v_q     <= 2'b00;
        end else begin
            credits <= credits + credit_t'(out_credit) - credit_t'(hit_valid);
            v_q     <= {v_q[0], in_pop};
        end
    end

    // register 1: nine products
    always_ff @(posedge clock) begin
        if (in_pop) begin
            for (int i = 0; i < 3; i++) begin
                for (int k = 0; k < 3; k++) begin
                    m_q[i][k] <= mul_wide(in_data.normal[k], c[i][k]);
                end
            end
        end
    end

    // sum wraps in 64 bits, then back to q format
    // a zero dot product counts as a miss
    always_comb begin
        hit_d = 1'b1;
        for (int i = 0; i < 3; i++) begin
            d[i]  = (m_q[i][0] + m_q[i][1] + m_q[i][2]) >>> q_bits;
            hit_d = hit_d && (d[i] > 0);
        end
    end

    // register 2: decision
    always_ff @(posedge clock) begin
        if (v_q[0]) begin
            hit <= hit_d;
        end
    end

endmodule

// ==== source/tri_hit_top.sv ====
module tri_hit_top import tri_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  in_valid,
    input  vec3_t v0,
    input  vec3_t v1,
    input  vec3_t v2,
    input  vec3_t normal,
    input  vec3_t p_hit,
    input  logic  out_credit,
    output logic  in_credit,
    output logic  hit_valid,
    output logic  hit
);

    // input FIFO side
    tri_in_t in_payload;
    tri_in_t tri_head;
    logic    tri_empty;
    logic    tri_pop;

    // edge link
    logic    edge_valid;
    edge_t   edge_data;
    edge_t   edge_head;
    logic    edge_empty;
    logic    edge_pop;
    logic    edge_credit;

    // cross link
    logic    cross_valid;
    cross_t  cross_data;
    cross_t  cross_head;
    logic    cross_empty;
    logic    cross_pop;
    logic    cross_credit;

    // loose vectors into one payload
    assign in_payload.v0     = v0;
    assign in_payload.v1     = v1;
    assign in_payload.v2     = v2;
    assign in_payload.normal = normal;
    assign in_payload.p_hit  = p_hit;

    // external writer holds the credits for this one
    credit_fifo #(.payload_t(tri_in_t)) u_fifo_in (
        .clock    (clock),
        .reset    (reset),
        .wr_valid (in_valid),
        .wr_data  (in_payload),
        .pop      (tri_pop),
        .rd_data  (tri_head),
        .empty    (tri_empty),
        .credit   (in_credit)
    );

    edge_sub_stage u_edge (
        .clock      (clock),
        .reset      (reset),
        .in_data    (tri_head),
        .in_empty   (tri_empty),
        .out_credit (edge_credit),
        .in_pop     (tri_pop),
        .out_valid  (edge_valid),
        .out_data   (edge_data)
    );

    credit_fifo #(.payload_t(edge_t)) u_fifo_edge (
        .clock    (clock),
        .reset    (reset),
        .wr_valid (edge_valid),
        .wr_data  (edge_data),
        .pop      (edge_pop),
        .rd_data  (edge_head),
        .empty    (edge_empty),
        .credit   (edge_credit)
    );

    cross_stage u_cross (
        .clock      (clock),
        .reset      (reset),
        .in_data    (edge_head),
        .in_empty   (edge_empty),
        .out_credit (cross_credit),
        .in_pop     (edge_pop),
        .out_valid  (cross_valid),
        .out_data   (cross_data)
    );

    credit_fifo #(.payload_t(cross_t)) u_fifo_cross (
        .clock    (clock),
        .reset    (reset),
        .wr_valid (cross_valid),
        .wr_data  (cross_data),
        .pop      (cross_pop),
        .rd_data  (cross_head),
        .empty    (cross_empty),
        .credit   (cross_credit)
    );

    // last stage talks to the external consumer
    sign_test_stage u_sign (
        .clock      (clock),
        .reset      (reset),
        .in_data    (cross_head),
        .in_empty   (cross_empty),
        .out_credit (out_credit),
        .in_pop     (cross_pop),
        .hit_valid  (hit_valid),
        .hit        (hit)
    );

endmodule

// ==== source/tri_pkg.sv ====
package tri_pkg;

    // fixed point format, q22.10
    localparam int q_bits = 10;

    // entries per credit FIFO, also the start credit of each sender
    localparam int fifo_depth = 4;
    // credits held for the external consumer
    localparam int out_credits = 4;

    // counter must cover the larger of the two credit pools
    localparam int max_credits  = (fifo_depth > out_credits) ? fifo_depth : out_credits;
    localparam int credit_w     = $clog2(max_credits + 1);
    // FIFO pointer and occupancy widths, depth of at least 2 assumed
    localparam int fifo_ptr_w   = $clog2(fifo_depth);
    localparam int fifo_count_w = $clog2(fifo_depth + 1);

    typedef logic [credit_w-1:0] credit_t;
    typedef logic signed [31:0]  coord_t;
    typedef logic signed [63:0]  prod_t;
    // index 0 is x, 1 is y, 2 is z
    typedef coord_t [0:2] vec3_t;

    // input FIFO payload, 480 bits
    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
        vec3_t normal;
        vec3_t p_hit;
    } tri_in_t;

    // edge vectors, point vectors, normal carried along
    typedef struct packed {
        vec3_t e0;
        vec3_t e1;
        vec3_t e2;
        vec3_t p0;
        vec3_t p1;
        vec3_t p2;
        vec3_t normal;
    } edge_t;

    // three cross products plus normal
    typedef struct packed {
        vec3_t c0;
        vec3_t c1;
        vec3_t c2;
        vec3_t normal;
    } cross_t;

    // per component difference, wraps on overflow
    function automatic vec3_t vec_sub(input vec3_t a, input vec3_t b);
        vec3_t r;
        for (int k = 0; k < 3; k++) begin
            r[k] = a[k] - b[k];
        end
        return r;
    endfunction

    // full 64 bit signed product of two coordinates
    function automatic prod_t mul_wide(input coord_t a, input coord_t b);
        return prod_t'(a) * prod_t'(b);
    endfunction

endpackage

// ==== tri_hit_top.f ====
+incdir+include
source/tri_pkg.sv
source/credit_fifo.sv
source/edge_sub_stage.sv
source/cross_stage.sv
source/sign_test_stage.sv
source/tri_hit_top.sv
verif/tri_hit_tb.sv

// ==== include/tri_hit_checks.svh ====
`ifndef TRI_HIT_CHECKS_SVH
`define TRI_HIT_CHECKS_SVH

// golden model of the full pipeline, same wraparound and shifts
function automatic logic hit_ref(input tri_pkg::vec3_t v0, input tri_pkg::vec3_t v1,
                                 input tri_pkg::vec3_t v2, input tri_pkg::vec3_t normal,
                                 input tri_pkg::vec3_t p_hit);
    tri_pkg::vec3_t e [3];
    tri_pkg::vec3_t p [3];
    tri_pkg::vec3_t c [3];
    longint         acc;
    logic           hit;
    hit = 1'b1;
    for (int k = 0; k < 3; k++) begin
        e[0][k] = v1[k] - v0[k];
        e[1][k] = v2[k] - v1[k];
        e[2][k] = v0[k] - v2[k];
        p[0][k] = p_hit[k] - v0[k];
        p[1][k] = p_hit[k] - v1[k];
        p[2][k] = p_hit[k] - v2[k];
    end
    for (int i = 0; i < 3; i++) begin
        for (int k = 0; k < 3; k++) begin
            acc = longint'(e[i][(k + 1) % 3]) * longint'(p[i][(k + 2) % 3])
                - longint'(e[i][(k + 2) % 3]) * longint'(p[i][(k + 1) % 3]);
            c[i][k] = tri_pkg::coord_t'(acc >>> tri_pkg::q_bits);
        end
        // dot product stays 64 bit
        acc = longint'(normal[0]) * longint'(c[i][0]) + longint'(normal[1]) * longint'(c[i][1])
            + longint'(normal[2]) * longint'(c[i][2]);
        hit = hit && ((acc >>> tri_pkg::q_bits) > 0);
    end
    return hit;
endfunction

task automatic check_hit(input string name, input logic expected, input logic actual,
                         inout int pass_count, inout int fail_count);
    if (actual === expected) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

task automatic check_credit_t(input string name, input tri_pkg::credit_t expected,
                              input tri_pkg::credit_t actual,
                              inout int pass_count, inout int fail_count);
    if (actual === expected) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

`endif

// ==== verif/tri_hit_tb.sv ====
module tri_hit_tb import tri_pkg::*;;

    logic    clock = 1'b0;
    logic    reset;
    logic    in_valid;
    vec3_t   v0;
    vec3_t   v1;
    vec3_t   v2;
    vec3_t   normal;
    vec3_t   p_hit;
    logic    out_credit;
    logic    in_credit;
    logic    hit_valid;
    logic    hit;

    // expected hits in input order
    logic    exp_q [$];
    // writer side credits and hits not yet returned to the DUT
    credit_t wr_credits;
    credit_t owed;
    int      valid_pulses;
    int      credit_pulses;
    int      pass_count;
    int      fail_count;
    // sink returns one credit per sink_ratio cycles on average
    int      sink_ratio;
    logic    long_holds;
    logic [31:0] stim_rng;
    logic [31:0] sink_rng;

    // item counts per test and for the watchdog
    int      directed_items = 7;
    int      random_items = 300;
    int      slow_items = 60;
    int      pre_reset_items = 8;
    int      post_reset_items = 40;

    `include "tri_hit_checks.svh"

    tri_hit_top dut (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .normal     (normal),
        .p_hit      (p_hit),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .hit_valid  (hit_valid),
        .hit        (hit)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] stim_next();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    function automatic vec3_t vec(input int x, input int y, input int z);
        vec3_t r;
        r[0] = coord_t'(x);
        r[1] = coord_t'(y);
        r[2] = coord_t'(z);
        return r;
    endfunction

    // credit bookkeeping on the falling edge where inputs and outputs are stable
    always @(negedge clock) begin
        if (reset) begin
            wr_credits    = credit_t'(fifo_depth);
            owed          = '0;
            valid_pulses  = 0;
            credit_pulses = 0;
        end else begin
            wr_credits    = wr_credits + credit_t'(in_credit) - credit_t'(in_valid);
            valid_pulses  = valid_pulses + int'(in_valid);
            credit_pulses = credit_pulses + int'(in_credit);
            if (wr_credits > credit_t'(fifo_depth)) begin
                fail_count++;
                $display("writer got back more credits than the input FIFO holds");
            end
            owed = owed + credit_t'(hit_valid) - credit_t'(out_credit);
            if (owed > credit_t'(out_credits)) begin
                fail_count++;
                $display("hit_valid sent beyond the consumer credits");
            end
        end
    end

    // scoreboard
    always @(negedge clock) begin : compare
        logic expected;
        if (!reset && hit_valid) begin
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("hit_valid arrived with no result expected");
            end else begin
                expected = exp_q.pop_front();
                check_hit("hit", expected, hit, pass_count, fail_count);
            end
        end
    end

    // consumer returns credits after a random delay and may stall for long stretches
    initial begin : sink
        int hold;
        hold       = 0;
        out_credit = 1'b0;
        sink_rng   = 32'h1ace;
        forever begin
            @(posedge clock);
            #1;
            out_credit = 1'b0;
            sink_rng   = xorshift(sink_rng);
            if (hold > 0) begin
                hold--;
            end else if (long_holds && sink_rng[9:4] == 6'd0) begin
                hold = 50;
            end else if (owed > '0 && (sink_rng % sink_ratio) == 0) begin
                out_credit = 1'b1;
            end
        end
    end

    initial begin : watchdog
        longint limit;
        limit = longint'(directed_items + random_items + slow_items + pre_reset_items
                         + post_reset_items) * 200 * 40;
        #(limit);
        $display("watchdog expired, the result stream stopped");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic apply_reset();
        reset = 1'b1;
        exp_q.delete();
        repeat (2) begin
            @(posedge clock);
        end
        #1;
        // async reset keeps both pulses low
        check_hit("hit_valid", 1'b0, hit_valid, pass_count, fail_count);
        check_hit("in_credit", 1'b0, in_credit, pass_count, fail_count);
        reset = 1'b0;
    endtask

    // waits for a credit and sends one valid cycle per item
    task automatic send_tri(input vec3_t a, input vec3_t b, input vec3_t c,
                            input vec3_t n, input vec3_t p);
        while (wr_credits == '0) begin
            @(posedge clock);
            #1;
        end
        v0       = a;
        v1       = b;
        v2       = c;
        normal   = n;
        p_hit    = p;
        in_valid = 1'b1;
        exp_q.push_back(hit_ref(a, b, c, n, p));
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_directed(input vec3_t a, input vec3_t b, input vec3_t c,
                                 input vec3_t n, input vec3_t p, input logic intended);
        // model must agree with the hand worked answer
        check_hit("hit_ref", intended, hit_ref(a, b, c, n, p), pass_count, fail_count);
        send_tri(a, b, c, n, p);
    endtask

    // point spread around the triangle in its plane
    task automatic random_tri(output vec3_t a, output vec3_t b, output vec3_t c,
                              output vec3_t n, output vec3_t p);
        vec3_t d1;
        vec3_t d2;
        int    wa;
        int    wb;
        logic  flip;
        for (int k = 0; k < 3; k++) begin
            a[k] = coord_t'(int'(stim_next() % 16384) - 8192);
            b[k] = coord_t'(int'(stim_next() % 16384) - 8192);
            c[k] = coord_t'(int'(stim_next() % 16384) - 8192);
        end
        d1   = vec_sub(b, a);
        d2   = vec_sub(c, a);
        wa   = int'(stim_next() % 384) - 64;
        wb   = int'(stim_next() % 384) - 64;
        // occasional flipped normal
        flip = (stim_next() % 8) == 0;
        for (int k = 0; k < 3; k++) begin
            p[k] = a[k] + coord_t'((wa * int'(d1[k]) + wb * int'(d2[k])) / 256);
            n[k] = coord_t'((longint'(d1[(k + 1) % 3]) * longint'(d2[(k + 2) % 3])
                           - longint'(d1[(k + 2) % 3]) * longint'(d2[(k + 1) % 3])) >>> q_bits);
            if (flip) begin
                n[k] = -n[k];
            end
        end
    endtask

    task automatic check_full_credits();
        check_credit_t("wr_credits", credit_t'(fifo_depth), wr_credits, pass_count, fail_count);
        check_credit_t("u_edge.credits", credit_t'(fifo_depth), dut.u_edge.credits,
                       pass_count, fail_count);
        check_credit_t("u_cross.credits", credit_t'(fifo_depth), dut.u_cross.credits,
                       pass_count, fail_count);
        check_credit_t("u_sign.credits", credit_t'(out_credits), dut.u_sign.credits,
                       pass_count, fail_count);
    endtask

    // drain and compare credits and pulse counts with their reset state
    task automatic finish_test(input string name, input int fails_before);
        while (exp_q.size() != 0 || owed != '0) begin
            @(posedge clock);
        end
        repeat (3) begin
            @(posedge clock);
        end
        #1;
        check_full_credits();
        if (credit_pulses != valid_pulses) begin
            fail_count++;
            $display("ERR in_credit_pulses expected %h actual %h", valid_pulses, credit_pulses);
        end
        $display("test %s done, %0d errors", name, fail_count - fails_before);
    endtask

    initial begin : main
        vec3_t a;
        vec3_t b;
        vec3_t c;
        vec3_t n;
        vec3_t p;
        int    fails_before;
        in_valid   = 1'b0;
        v0         = '0;
        v1         = '0;
        v2         = '0;
        normal     = '0;
        p_hit      = '0;
        stim_rng   = 32'h1ace;
        wr_credits = credit_t'(fifo_depth);
        owed       = '0;
        pass_count = 0;
        fail_count = 0;
        sink_ratio = 2;
        long_holds = 1'b0;
        apply_reset();

        // right triangle in the xy plane with the normal along +z
        fails_before = fail_count;
        a = vec(0, 0, 0);
        b = vec(4096, 0, 0);
        c = vec(0, 4096, 0);
        n = vec(0, 0, 1024);
        send_directed(a, b, c, n, vec(1024, 1024, 0), 1'b1);
        send_directed(a, b, c, n, vec(5000, 5000, 0), 1'b0);
        send_directed(vec(0, 0, 0), vec(0, 0, 4096), vec(4096, 0, 0), vec(0, 1024, 0),
                      vec(1024, 0, 1024), 1'b1);
        finish_test("inside_outside", fails_before);

        // zero dot products and wrong winding
        fails_before = fail_count;
        send_directed(a, b, c, n, vec(2048, 0, 0), 1'b0);
        send_directed(a, b, c, n, vec(0, 0, 0), 1'b0);
        send_directed(a, c, b, n, vec(1024, 1024, 0), 1'b0);
        send_directed(a, b, c, vec(0, 0, -1024), vec(1024, 1024, 0), 1'b0);
        finish_test("edge_vertex_winding", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < random_items; i++) begin
            random_tri(a, b, c, n, p);
            send_tri(a, b, c, n, p);
        end
        finish_test("random", fails_before);

        // slow consumer with long stalls
        fails_before = fail_count;
        sink_ratio   = 6;
        long_holds   = 1'b1;
        for (int i = 0; i < slow_items; i++) begin
            random_tri(a, b, c, n, p);
            send_tri(a, b, c, n, p);
        end
        finish_test("back_pressure", fails_before);
        sink_ratio = 2;
        long_holds = 1'b0;

        // reset with items still in flight and a fresh stream after it
        fails_before = fail_count;
        for (int i = 0; i < pre_reset_items; i++) begin
            random_tri(a, b, c, n, p);
            send_tri(a, b, c, n, p);
        end
        apply_reset();
        @(posedge clock);
        #1;
        check_hit("hit_valid", 1'b0, hit_valid, pass_count, fail_count);
        check_full_credits();
        for (int i = 0; i < post_reset_items; i++) begin
            random_tri(a, b, c, n, p);
            send_tri(a, b, c, n, p);
        end
        finish_test("reset_mid_stream", fails_before);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
